// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= -sv --timing --assert
TOP       := rs_station_tb
FILELIST  := compile.f
LOG       := sim.log

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

obj_dir/V$(TOP): $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "=== FAIL ===" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "=== PASS ===" $(LOG); then echo "Simulation ended early"; exit 1; fi

clean:
	rm -rf obj_dir $(LOG)

// ==== compile.f ====
rtl/rs_pkg.sv
rtl/rs_cdb_if.sv
rtl/rs_busy_timer.sv
rtl/rs_mult_ctrl.sv
rtl/rs_entry.sv
rtl/rs_select.sv
rtl/rs_station.sv
verification/rs_station_properties.sv
verification/rs_station_checker.sv
verification/rs_station_tb.sv

// ==== rtl/rs_busy_timer.sv ====
/*
 * Busy down-counter. Loads MULT_CYCLES on start and counts to zero.
 * expired is high while the count reads one, the last busy cycle.
 * MULT_CYCLES must be at least one.
 */
`timescale 1ns/100ps
`default_nettype none

module rs_busy_timer #(
	parameter int MULT_CYCLES = 4
) (
	input  wire logic clock,
	input  wire logic reset,
	input  wire logic start,
	output logic      expired
);

	localparam int CNT_BITS = $clog2(MULT_CYCLES + 1);

	logic [CNT_BITS-1:0] count;		// Busy cycles left, zero when idle

	always_ff @(posedge clock)
	begin
		if (reset)
			count <= '0;
		else if (start)
			count <= CNT_BITS'(MULT_CYCLES);
		else if (count != '0)
			count <= count - 1'b1;
	end

	assign expired = (count == CNT_BITS'(1));

endmodule

`default_nettype wire

// ==== rtl/rs_cdb_if.sv ====
/*
 * Two common data buses, each a value, a tag and a one-cycle valid strobe.
 * No handshake, so every snooper sees the broadcast in the same cycle.
 */
`timescale 1ns/100ps
`default_nettype none

interface rs_cdb_if;

	logic [rs_pkg::XLEN-1:0]     cdb1_value;	// Bus 1 result
	logic [rs_pkg::PRN_BITS-1:0] cdb1_tag;		// Bus 1 destination tag
	logic                        cdb1_valid;	// Bus 1 strobe
	logic [rs_pkg::XLEN-1:0]     cdb2_value;	// Bus 2 result
	logic [rs_pkg::PRN_BITS-1:0] cdb2_tag;		// Bus 2 destination tag
	logic                        cdb2_valid;	// Bus 2 strobe

	// Driver side
	modport source (output cdb1_value, cdb1_tag, cdb1_valid,
			cdb2_value, cdb2_tag, cdb2_valid);
	// Entry side
	modport snoop (input cdb1_value, cdb1_tag, cdb1_valid,
			cdb2_value, cdb2_tag, cdb2_valid);

endinterface

`default_nettype wire

// ==== rtl/rs_entry.sv ====
/*
 * One reservation entry. A load wins over a CDB match in the same cycle,
 * so a broadcast in the dispatch cycle is missed.
 * If both buses carry the pending tag, bus 2 supplies the value.
 */
`timescale 1ns/100ps
`default_nettype none

module rs_entry (
	input  wire logic                             clock,
	input  wire logic                             reset,
	input  wire logic                             load,		// One-hot slot from select
	input  wire rs_pkg::rs_operand_t              opa_in,
	input  wire rs_pkg::rs_operand_t              opb_in,
	input  wire logic                             opa_valid,	// Value, not tag
	input  wire logic                             opb_valid,
	input  wire logic [rs_pkg::PRN_BITS-1:0]      dest_in,
	input  wire logic [rs_pkg::ROB_BITS-1:0]      rob_idx_in,
	input  wire logic [rs_pkg::OP_TYPE_BITS-1:0]  op_type_in,
	input  wire rs_pkg::alu_func_t                alu_func_in,
	input  wire rs_pkg::fu_select_t               fu_select_in,
	rs_cdb_if.snoop                               cdb,
	input  wire logic                             adder_available,
	input  wire logic                             mult_available,
	input  wire logic                             memory_available,
	input  wire logic                             issue_grant,	// This entry goes out now
	output logic                                  free,
	output logic                                  ready,
	output rs_pkg::rs_operand_t                   opa,
	output rs_pkg::rs_operand_t                   opb,
	output logic [rs_pkg::PRN_BITS-1:0]           dest_tag,
	output logic [rs_pkg::ROB_BITS-1:0]           rob_idx,
	output logic [rs_pkg::OP_TYPE_BITS-1:0]       op_type,
	output rs_pkg::alu_func_t                     alu_func,
	output rs_pkg::fu_select_t                    fu_select
);

	logic in_use;			// Entry holds an instruction
	logic opa_ok;			// Operand A is a value
	logic opb_ok;			// Operand B is a value
	logic a_hit1, a_hit2;		// Operand A tag seen on bus 1 / 2
	logic b_hit1, b_hit2;		// Operand B tag seen on bus 1 / 2
	logic fu_ready;			// Selected unit can take work

	//////////////////////////////////////////////////////////////////////
	// CDB snoop
	//////////////////////////////////////////////////////////////////////

	assign a_hit1 = in_use && !opa_ok && cdb.cdb1_valid && (cdb.cdb1_tag == opa.prn.tag);
	assign a_hit2 = in_use && !opa_ok && cdb.cdb2_valid && (cdb.cdb2_tag == opa.prn.tag);
	assign b_hit1 = in_use && !opb_ok && cdb.cdb1_valid && (cdb.cdb1_tag == opb.prn.tag);
	assign b_hit2 = in_use && !opb_ok && cdb.cdb2_valid && (cdb.cdb2_tag == opb.prn.tag);

	always_comb
	begin
		case (fu_select)
			rs_pkg::USE_ADDER:      fu_ready = adder_available;
			rs_pkg::USE_MULTIPLIER: fu_ready = mult_available;
			rs_pkg::USE_MEMORY:     fu_ready = memory_available;
			default:                fu_ready = 1'b0;	// FU_NONE never issues
		endcase
	end

	assign free  = !in_use;
	assign ready = in_use && opa_ok && opb_ok && fu_ready;

	//////////////////////////////////////////////////////////////////////
	// State
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			in_use <= 1'b0;
			opa_ok <= 1'b0;
			opb_ok <= 1'b0;
		end
		else if (load)
		begin
			in_use <= 1'b1;
			opa_ok <= opa_valid;
			opb_ok <= opb_valid;
		end
		else
		begin
			if (a_hit1 || a_hit2)
				opa_ok <= 1'b1;
			if (b_hit1 || b_hit2)
				opb_ok <= 1'b1;
			if (issue_grant)
				in_use <= 1'b0;		// Free from next cycle
		end
	end

	// Payload, only meaningful while in_use
	always_ff @(posedge clock)
	begin
		if (load)
		begin
			opa       <= opa_in;
			opb       <= opb_in;
			dest_tag  <= dest_in;
			rob_idx   <= rob_idx_in;
			op_type   <= op_type_in;
			alu_func  <= alu_func_in;
			fu_select <= fu_select_in;
		end
		else
		begin
			if (a_hit2)
				opa.value <= cdb.cdb2_value;	// Bus 2 wins a tie
			else if (a_hit1)
				opa.value <= cdb.cdb1_value;
			if (b_hit2)
				opb.value <= cdb.cdb2_value;
			else if (b_hit1)
				opb.value <= cdb.cdb1_value;
		end
	end

endmodule

`default_nettype wire

// ==== rtl/rs_mult_ctrl.sv ====
/*
 * Multiplier occupancy for an unpipelined unit.
 * After a multiply issues in cycle t the unit is busy through t+MULT_CYCLES,
 * with mult_done in that last cycle.
 */
`timescale 1ns/100ps
`default_nettype none

module rs_mult_ctrl #(
	parameter int MULT_CYCLES = 4
) (
	input  wire logic clock,
	input  wire logic reset,
	input  wire logic mult_issue,		// Multiply granted this cycle
	input  wire logic expired,		// Tied off at the top
	output logic      start,		// Load busy timer
	output logic      mult_available,
	output logic      mult_done
);

	typedef enum logic {
		IDLE,
		BUSY
	} state_t;

	state_t state;
	logic   timer_expired;			// Last busy cycle, from u_timer

	assign start          = mult_issue && (state == IDLE);
	assign mult_available = (state == IDLE);
	assign mult_done      = (state == BUSY) && timer_expired;

	always_ff @(posedge clock)
	begin
		if (reset)
			state <= IDLE;
		else
		begin
			case (state)
				IDLE: if (start) state <= BUSY;
				BUSY: if (timer_expired) state <= IDLE;	// Free next cycle
				default: state <= IDLE;
			endcase
		end
	end

	rs_busy_timer #(
		.MULT_CYCLES(MULT_CYCLES)
	) u_timer (
		.clock   (clock),
		.reset   (reset),
		.start   (start),
		.expired (timer_expired)
	);

endmodule

`default_nettype wire

// ==== rtl/rs_pkg.sv ====
/*
 * Shared widths and types for the reservation station.
 * An operand is one XLEN word, read as a value or as a tag by its valid bit.
 * fu_select_t zero means no unit, and such an entry never becomes ready.
 */
`default_nettype none

package rs_pkg;

	localparam int XLEN         = 64;		// Data path width
	localparam int PRN_BITS     = 6;		// Physical register tag width
	localparam int ROB_BITS     = 5;		// Reorder buffer index width
	localparam int OP_TYPE_BITS = 6;		// Instruction type width

	// Functional unit an instruction needs
	typedef enum logic [1:0] {
		FU_NONE        = 2'd0,			// Never ready
		USE_ADDER      = 2'd1,
		USE_MULTIPLIER = 2'd2,
		USE_MEMORY     = 2'd3
	} fu_select_t;

	// ALU functions, passed through to the issue bus as is
	typedef enum logic [4:0] {
		ALU_ADDQ, ALU_SUBQ, ALU_AND, ALU_BIC,
		ALU_BIS, ALU_ORNOT, ALU_XOR, ALU_EQV,
		ALU_SRL, ALU_SLL, ALU_SRA, ALU_MULQ,
		ALU_CMPEQ, ALU_CMPLT, ALU_CMPLE, ALU_CMPULT,
		ALU_CMPULE
	} alu_func_t;

	// Operand word, a value when valid, else a tag in the low bits
	typedef union packed {
		logic [XLEN-1:0] value;			// Valid view
		struct packed {
			logic [XLEN-PRN_BITS-1:0] pad;	// Don't care
			logic [PRN_BITS-1:0]      tag;	// Producer's physical register
		} prn;					// Pending view
	} rs_operand_t;

endpackage

`default_nettype wire

// ==== rtl/rs_select.sv ====
/*
 * Allocation and issue select, both lowest index first.
 * A dispatch with no free entry is dropped here.
 * The issue bus follows the chosen entry every cycle, qualified by issue_valid.
 */
`timescale 1ns/100ps
`default_nettype none

module rs_select #(
	parameter int NUM_ENTRIES = 8
) (
	input  wire logic                             dispatch_valid,
	input  wire logic [NUM_ENTRIES-1:0]           free,
	input  wire logic [NUM_ENTRIES-1:0]           ready,
	input  wire rs_pkg::rs_operand_t              opa [NUM_ENTRIES],
	input  wire rs_pkg::rs_operand_t              opb [NUM_ENTRIES],
	input  wire logic [rs_pkg::PRN_BITS-1:0]      dest_tag [NUM_ENTRIES],
	input  wire logic [rs_pkg::ROB_BITS-1:0]      rob_idx [NUM_ENTRIES],
	input  wire logic [rs_pkg::OP_TYPE_BITS-1:0]  op_type [NUM_ENTRIES],
	input  wire rs_pkg::alu_func_t                alu_func [NUM_ENTRIES],
	input  wire rs_pkg::fu_select_t               fu_select [NUM_ENTRIES],
	output logic [NUM_ENTRIES-1:0]                load,		// One-hot allocate
	output logic [NUM_ENTRIES-1:0]                issue_grant,	// One-hot issue
	output logic                                  rs_full,
	output logic                                  issue_valid,
	output logic [rs_pkg::XLEN-1:0]               issue_opa,
	output logic [rs_pkg::XLEN-1:0]               issue_opb,
	output logic [rs_pkg::PRN_BITS-1:0]           issue_dest_tag,
	output logic [rs_pkg::ROB_BITS-1:0]           issue_rob_idx,
	output logic [rs_pkg::OP_TYPE_BITS-1:0]       issue_op_type,
	output rs_pkg::alu_func_t                     issue_alu_func,
	output logic                                  mult_issue	// Starts multiplier timer
);

	localparam int IDX_BITS = (NUM_ENTRIES > 1) ? $clog2(NUM_ENTRIES) : 1;

	logic [IDX_BITS-1:0] free_idx;		// Lowest free slot
	logic [IDX_BITS-1:0] issue_idx;		// Lowest ready slot

	// Priority encoder, lowest set bit wins
	function automatic logic [IDX_BITS-1:0] lowest_set(input logic [NUM_ENTRIES-1:0] vec);
		logic [IDX_BITS-1:0] idx;
		idx = '0;
		for (int i = NUM_ENTRIES - 1; i >= 0; i--)
			if (vec[i])
				idx = IDX_BITS'(i);
		return idx;
	endfunction

	//////////////////////////////////////////////////////////////////////
	// Allocate
	//////////////////////////////////////////////////////////////////////

	assign free_idx = lowest_set(free);
	assign rs_full  = ~|free;
	assign load     = (dispatch_valid && !rs_full) ? (NUM_ENTRIES'(1) << free_idx) : '0;

	//////////////////////////////////////////////////////////////////////
	// Issue
	//////////////////////////////////////////////////////////////////////

	assign issue_idx   = lowest_set(ready);
	assign issue_valid = |ready;
	assign issue_grant = issue_valid ? (NUM_ENTRIES'(1) << issue_idx) : '0;

	assign issue_opa      = opa[issue_idx].value;	// Both operands are values here
	assign issue_opb      = opb[issue_idx].value;
	assign issue_dest_tag = dest_tag[issue_idx];
	assign issue_rob_idx  = rob_idx[issue_idx];
	assign issue_op_type  = op_type[issue_idx];
	assign issue_alu_func = alu_func[issue_idx];

	assign mult_issue = issue_valid && (fu_select[issue_idx] == rs_pkg::USE_MULTIPLIER);

endmodule

`default_nettype wire

// ==== rtl/rs_station.sv ====
/*
 * Reservation station top. One dispatch and at most one issue per cycle.
 * Dispatch while rs_full is dropped. Issue fields are valid only with issue_valid.
 * The multiplier is tracked inside, adder and memory availability come from outside.
 */
`timescale 1ns/100ps
`default_nettype none

module rs_station #(
	parameter int NUM_ENTRIES = 8,
	parameter int MULT_CYCLES = 4
) (
	input  wire logic                             clock,
	input  wire logic                             reset,
	input  wire logic                             dispatch_valid,
	input  wire rs_pkg::rs_operand_t              opa_in,
	input  wire rs_pkg::rs_operand_t              opb_in,
	input  wire logic                             opa_valid,
	input  wire logic                             opb_valid,
	input  wire logic [rs_pkg::PRN_BITS-1:0]      dest_in,
	input  wire logic [rs_pkg::ROB_BITS-1:0]      rob_idx_in,
	input  wire logic [rs_pkg::OP_TYPE_BITS-1:0]  op_type_in,
	input  wire rs_pkg::alu_func_t                alu_func_in,
	input  wire rs_pkg::fu_select_t               fu_select_in,
	input  wire logic [rs_pkg::XLEN-1:0]          cdb1_value,
	input  wire logic [rs_pkg::PRN_BITS-1:0]      cdb1_tag,
	input  wire logic                             cdb1_valid,
	input  wire logic [rs_pkg::XLEN-1:0]          cdb2_value,
	input  wire logic [rs_pkg::PRN_BITS-1:0]      cdb2_tag,
	input  wire logic                             cdb2_valid,
	input  wire logic                             adder_available,
	input  wire logic                             memory_available,
	output logic                                  rs_full,
	output logic                                  issue_valid,
	output logic [rs_pkg::XLEN-1:0]               issue_opa,
	output logic [rs_pkg::XLEN-1:0]               issue_opb,
	output logic [rs_pkg::PRN_BITS-1:0]           issue_dest_tag,
	output logic [rs_pkg::ROB_BITS-1:0]           issue_rob_idx,
	output logic [rs_pkg::OP_TYPE_BITS-1:0]       issue_op_type,
	output rs_pkg::alu_func_t                     issue_alu_func,
	output logic                                  mult_done
);

	logic [NUM_ENTRIES-1:0]            entry_free;
	logic [NUM_ENTRIES-1:0]            entry_ready;
	logic [NUM_ENTRIES-1:0]            load;
	logic [NUM_ENTRIES-1:0]            issue_grant;
	rs_pkg::rs_operand_t               entry_opa [NUM_ENTRIES];
	rs_pkg::rs_operand_t               entry_opb [NUM_ENTRIES];
	logic [rs_pkg::PRN_BITS-1:0]       entry_dest [NUM_ENTRIES];
	logic [rs_pkg::ROB_BITS-1:0]       entry_rob [NUM_ENTRIES];
	logic [rs_pkg::OP_TYPE_BITS-1:0]   entry_op_type [NUM_ENTRIES];
	rs_pkg::alu_func_t                 entry_alu_func [NUM_ENTRIES];
	rs_pkg::fu_select_t                entry_fu [NUM_ENTRIES];
	logic                              mult_issue;
	logic                              mult_available;

	//////////////////////////////////////////////////////////////////////
	// CDB fan-out, source side
	//////////////////////////////////////////////////////////////////////

	rs_cdb_if cdb ();

	assign cdb.cdb1_value = cdb1_value;
	assign cdb.cdb1_tag   = cdb1_tag;
	assign cdb.cdb1_valid = cdb1_valid;
	assign cdb.cdb2_value = cdb2_value;
	assign cdb.cdb2_tag   = cdb2_tag;
	assign cdb.cdb2_valid = cdb2_valid;

	for (genvar i = 0; i < NUM_ENTRIES; i++)
	begin : g_entry
		rs_entry u_entry (
			.clock(clock), .reset(reset), .load(load[i]),
			.opa_in(opa_in), .opb_in(opb_in),
			.opa_valid(opa_valid), .opb_valid(opb_valid),
			.dest_in(dest_in), .rob_idx_in(rob_idx_in), .op_type_in(op_type_in),
			.alu_func_in(alu_func_in), .fu_select_in(fu_select_in),
			.cdb(cdb.snoop),
			.adder_available(adder_available), .mult_available(mult_available),
			.memory_available(memory_available), .issue_grant(issue_grant[i]),
			.free(entry_free[i]), .ready(entry_ready[i]),
			.opa(entry_opa[i]), .opb(entry_opb[i]),
			.dest_tag(entry_dest[i]), .rob_idx(entry_rob[i]),
			.op_type(entry_op_type[i]), .alu_func(entry_alu_func[i]),
			.fu_select(entry_fu[i])
		);
	end

	rs_select #(.NUM_ENTRIES(NUM_ENTRIES)) u_select (
		.dispatch_valid(dispatch_valid), .free(entry_free), .ready(entry_ready),
		.opa(entry_opa), .opb(entry_opb), .dest_tag(entry_dest), .rob_idx(entry_rob),
		.op_type(entry_op_type), .alu_func(entry_alu_func), .fu_select(entry_fu),
		.load(load), .issue_grant(issue_grant), .rs_full(rs_full),
		.issue_valid(issue_valid), .issue_opa(issue_opa), .issue_opb(issue_opb),
		.issue_dest_tag(issue_dest_tag), .issue_rob_idx(issue_rob_idx),
		.issue_op_type(issue_op_type), .issue_alu_func(issue_alu_func),
		.mult_issue(mult_issue)
	);

	// Busy timer sits inside the controller
	rs_mult_ctrl #(.MULT_CYCLES(MULT_CYCLES)) u_mult_ctrl (
		.clock(clock), .reset(reset),
		.mult_issue(mult_issue), .expired(1'b0),
		.start(), .mult_available(mult_available),
		.mult_done(mult_done)
	);

endmodule

`default_nettype wire

// ==== verification/rs_station_checker.sv ====
/*
 * Reference model of the station, driven from the UUT's ports only.
 * Compares each cycle at the falling edge. Cycles in reset are not compared.
 * Also compares the stimulus table's expected issue when exp_check is high.
 */
`timescale 1ns/100ps
`default_nettype none

module rs_station_checker #(
	parameter int NUM_ENTRIES = 4,
	parameter int MULT_CYCLES = 4
) (
	input  wire logic                            clock,
	input  wire logic                            reset,
	input  wire logic                            dispatch_valid,
	input  wire logic [rs_pkg::XLEN-1:0]         opa_in,
	input  wire logic [rs_pkg::XLEN-1:0]         opb_in,
	input  wire logic                            opa_valid,
	input  wire logic                            opb_valid,
	input  wire logic [rs_pkg::PRN_BITS-1:0]     dest_in,
	input  wire logic [rs_pkg::ROB_BITS-1:0]     rob_idx_in,
	input  wire logic [rs_pkg::OP_TYPE_BITS-1:0] op_type_in,
	input  wire logic [4:0]                      alu_func_in,
	input  wire logic [1:0]                      fu_select_in,
	input  wire logic [rs_pkg::XLEN-1:0]         cdb1_value,
	input  wire logic [rs_pkg::PRN_BITS-1:0]     cdb1_tag,
	input  wire logic                            cdb1_valid,
	input  wire logic [rs_pkg::XLEN-1:0]         cdb2_value,
	input  wire logic [rs_pkg::PRN_BITS-1:0]     cdb2_tag,
	input  wire logic                            cdb2_valid,
	input  wire logic                            adder_available,
	input  wire logic                            memory_available,
	input  wire logic                            rs_full,
	input  wire logic                            issue_valid,
	input  wire logic [rs_pkg::XLEN-1:0]         issue_opa,
	input  wire logic [rs_pkg::XLEN-1:0]         issue_opb,
	input  wire logic [rs_pkg::PRN_BITS-1:0]     issue_dest_tag,
	input  wire logic [rs_pkg::ROB_BITS-1:0]     issue_rob_idx,
	input  wire logic [rs_pkg::OP_TYPE_BITS-1:0] issue_op_type,
	input  wire logic [4:0]                      issue_alu_func,
	input  wire logic                            mult_done,
	input  wire logic                            exp_check,	// Table row has an expectation
	input  wire logic                            exp_valid,
	input  wire logic [rs_pkg::ROB_BITS-1:0]     exp_rob,
	output int                                   errors
);

	logic        used [NUM_ENTRIES];			// Model entry state
	logic        aok [NUM_ENTRIES];
	logic        bok [NUM_ENTRIES];
	logic [63:0] aval [NUM_ENTRIES];
	logic [63:0] bval [NUM_ENTRIES];
	logic [63:0] meta [NUM_ENTRIES];			// {fu, alu, op_type, rob, dest}
	int          mcnt;					// Multiplier busy cycles left

	initial errors = 0;

	task automatic compare_field(input string name, input logic [63:0] got,
			input logic [63:0] exp);
		if (got !== exp)
		begin
			errors++;
			$display("[FAIL] %0t %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	always @(negedge clock)
	begin : model
		int  rsel;
		int  fsel;
		logic rdy;
		logic avail;
		rsel = -1;
		fsel = -1;
		if (reset)
		begin
			mcnt = 0;
			for (int i = 0; i < NUM_ENTRIES; i++)
				used[i] = 1'b0;
		end
		else
		begin
			for (int i = NUM_ENTRIES - 1; i >= 0; i--)
			begin
				case (meta[i][25:24])				// Unit needed
					2'd1:    avail = adder_available;
					2'd2:    avail = (mcnt == 0);
					2'd3:    avail = memory_available;
					default: avail = 1'b0;
				endcase
				rdy = used[i] && aok[i] && bok[i] && avail;
				if (rdy)
					rsel = i;
				if (!used[i])
					fsel = i;
			end
			compare_field("issue_valid", 64'(issue_valid), 64'(rsel >= 0));
			compare_field("rs_full", 64'(rs_full), 64'(fsel < 0));
			compare_field("mult_done", 64'(mult_done), 64'(mcnt == 1));
			if (rsel >= 0)
			begin
				compare_field("issue_opa", issue_opa, aval[rsel]);
				compare_field("issue_opb", issue_opb, bval[rsel]);
				compare_field("issue_dest_tag", 64'(issue_dest_tag), 64'(meta[rsel][5:0]));
				compare_field("issue_rob_idx", 64'(issue_rob_idx), 64'(meta[rsel][10:6]));
				compare_field("issue_op_type", 64'(issue_op_type), 64'(meta[rsel][16:11]));
				compare_field("issue_alu_func", 64'(issue_alu_func), 64'(meta[rsel][21:17]));
			end
			if (exp_check)
			begin
				compare_field("issue_valid (table)", 64'(issue_valid), 64'(exp_valid));
				if (exp_valid)
					compare_field("issue_rob_idx (table)", 64'(issue_rob_idx), 64'(exp_rob));
			end
			// Next state
			if (mcnt > 0)
				mcnt--;
			for (int i = 0; i < NUM_ENTRIES; i++)
			begin
				if (used[i] && !aok[i] && cdb2_valid && cdb2_tag == aval[i][5:0])
					{aok[i], aval[i]} = {1'b1, cdb2_value};	// Bus 2 first
				else if (used[i] && !aok[i] && cdb1_valid && cdb1_tag == aval[i][5:0])
					{aok[i], aval[i]} = {1'b1, cdb1_value};
				if (used[i] && !bok[i] && cdb2_valid && cdb2_tag == bval[i][5:0])
					{bok[i], bval[i]} = {1'b1, cdb2_value};
				else if (used[i] && !bok[i] && cdb1_valid && cdb1_tag == bval[i][5:0])
					{bok[i], bval[i]} = {1'b1, cdb1_value};
			end
			if (rsel >= 0)
			begin
				used[rsel] = 1'b0;
				if (meta[rsel][25:24] == 2'd2)
					mcnt = MULT_CYCLES;
			end
			if (dispatch_valid && fsel >= 0)			// Full station drops it
			begin
				used[fsel] = 1'b1;
				aok[fsel]  = opa_valid;
				bok[fsel]  = opb_valid;
				aval[fsel] = opa_in;
				bval[fsel] = opb_in;
				meta[fsel] = 64'({fu_select_in, 2'b00, alu_func_in, op_type_in,
						rob_idx_in, dest_in});
			end
		end
	end

endmodule

`default_nettype wire

// ==== verification/rs_station_properties.sv ====
/*
 * Concurrent checks bound into rs_station. Reports through $error only.
 */
`timescale 1ns/100ps
`default_nettype none

module rs_station_properties #(
	parameter int NUM_ENTRIES = 4
) (
	input wire logic                   clock,
	input wire logic                   reset,
	input wire logic                   issue_valid,
	input wire logic                   mult_done,
	input wire logic                   mult_available,
	input wire logic                   mult_issue,
	input wire logic                   dispatch_valid,
	input wire logic                   rs_full,
	input wire logic [NUM_ENTRIES-1:0] entry_free,
	input wire logic [NUM_ENTRIES-1:0] issue_grant
);

	// All entries free after reset
	a_reset_idle: assert property (@(posedge clock) reset |=> !issue_valid)
		else $error("issue_valid high right after reset");

	// Unit free again after the done pulse
	a_done_frees: assert property (@(posedge clock) disable iff (reset)
		mult_done |=> mult_available)
		else $error("multiplier not available after mult_done");

	a_no_mult_busy: assert property (@(posedge clock) disable iff (reset)
		!mult_available |-> !mult_issue)
		else $error("multiply issued while multiplier busy");

	// Dropped dispatch takes no entry, only the issued one frees up
	a_full_drop: assert property (@(posedge clock) disable iff (reset)
		(dispatch_valid && rs_full) |=> (entry_free == $past(issue_grant)))
		else $error("dispatch to a full station changed the entries");

endmodule

bind rs_station rs_station_properties #(.NUM_ENTRIES(NUM_ENTRIES)) u_props (
	.clock(clock), .reset(reset), .issue_valid(issue_valid), .mult_done(mult_done),
	.mult_available(mult_available), .mult_issue(mult_issue),
	.dispatch_valid(dispatch_valid), .rs_full(rs_full),
	.entry_free(entry_free), .issue_grant(issue_grant)
);

`default_nettype wire

// ==== verification/rs_station_tb.sv ====
/*
 * Testbench for rs_station with 4 entries and a 4-cycle multiplier.
 * Table rows drive one cycle each, 1 ns after the rising edge.
 * Operand and CDB values come from a 32-bit LCG.
 */
`timescale 1ns/100ps
`default_nettype none

module rs_station_tb;

	localparam int NUM_ENTRIES = 4;
	localparam int MULT_CYCLES = 4;
	localparam int ROWS        = 38;

	// Columns: rst dv av bv ta tb rob fu c1 t1 c2 t2 add mem xv xrob
	typedef struct packed {
		logic rst; logic dv; logic av; logic bv;
		logic [5:0] ta; logic [5:0] tb; logic [4:0] rob; logic [1:0] fu;
		logic c1; logic [5:0] t1; logic c2; logic [5:0] t2;
		logic add; logic mem; logic xv; logic [4:0] xrob;
	} row_t;

	row_t rows [ROWS];
	logic clock, reset, dispatch_valid, opa_valid, opb_valid;
	rs_pkg::rs_operand_t opa_in, opb_in;
	logic [5:0] dest_in, op_type_in, cdb1_tag, cdb2_tag, issue_dest_tag, issue_op_type;
	logic [4:0] rob_idx_in, issue_rob_idx;
	rs_pkg::alu_func_t alu_func_in, issue_alu_func;
	rs_pkg::fu_select_t fu_select_in;
	logic [63:0] cdb1_value, cdb2_value, issue_opa, issue_opb;
	logic cdb1_valid, cdb2_valid, adder_available, memory_available;
	logic rs_full, issue_valid, mult_done, exp_check, exp_valid;
	logic [4:0] exp_rob;
	logic [31:0] lcg_state;
	int errors, timeouts, cycles;

	rs_station #(.NUM_ENTRIES(NUM_ENTRIES), .MULT_CYCLES(MULT_CYCLES)) UUT (.*);

	rs_station_checker #(.NUM_ENTRIES(NUM_ENTRIES), .MULT_CYCLES(MULT_CYCLES)) u_checker (
		.alu_func_in(5'(alu_func_in)), .fu_select_in(2'(fu_select_in)),
		.issue_alu_func(5'(issue_alu_func)), .opa_in(opa_in.value),
		.opb_in(opb_in.value), .errors(errors), .*);

	function logic [31:0] lcg_step();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state;
	endfunction

	task automatic apply_row(input row_t r);
		reset            = r.rst;
		dispatch_valid   = r.dv;
		opa_valid        = r.av;
		opb_valid        = r.bv;
		opa_in.value     = {lcg_step(), lcg_step()};
		opb_in.value     = {lcg_step(), lcg_step()};
		if (!r.av)
			opa_in.prn.tag = r.ta;		// Pending operand
		if (!r.bv)
			opb_in.prn.tag = r.tb;
		rob_idx_in       = r.rob;
		dest_in          = {1'b1, r.rob};
		op_type_in       = {1'b0, r.rob};
		fu_select_in     = rs_pkg::fu_select_t'(r.fu);
		alu_func_in      = (r.fu == 2'd2) ? rs_pkg::ALU_MULQ : rs_pkg::ALU_ADDQ;
		cdb1_valid       = r.c1;
		cdb1_tag         = r.t1;
		cdb1_value       = {lcg_step(), lcg_step()};
		cdb2_valid       = r.c2;
		cdb2_tag         = r.t2;
		cdb2_value       = {lcg_step(), lcg_step()};
		adder_available  = r.add;
		memory_available = r.mem;
		exp_valid        = r.xv;
		exp_rob          = r.xrob;
	endtask

	initial
	begin
		clock = 1'b0;
		forever #2 clock = ~clock;
	end

	initial
	begin
		lcg_state = 32'd17621;
		timeouts  = 0;
		exp_check = 1'b0;
		for (int i = 0; i < ROWS; i++)
			rows[i] = '{0,0,0,0,0,0,0,0,0,0,0,0,1,1,0,0};	// Idle
		rows[0]  = '{0,1,1,1,0,0,1,1,0,0,0,0,1,1,0,0};		// Values only
		rows[1]  = '{0,0,0,0,0,0,0,0,0,0,0,0,1,1,1,1};
		rows[2]  = '{0,1,0,0,5,6,2,1,1,5,0,0,1,1,0,0};		// Missed broadcast
		rows[3]  = '{0,0,0,0,0,0,0,0,0,0,1,6,1,1,0,0};
		rows[4]  = '{0,0,0,0,0,0,0,0,1,5,0,0,1,1,0,0};
		rows[5]  = '{0,0,0,0,0,0,0,0,0,0,0,0,1,1,1,2};
		for (int i = 6; i < 9; i++)				// Adder held off
			rows[i] = '{0,1,1,1,0,0,5'(i-3),1,0,0,0,0,0,1,0,0};
		for (int i = 9; i < 12; i++)
			rows[i] = '{0,0,0,0,0,0,0,0,0,0,0,0,1,1,1,5'(i-6)};
		rows[12] = '{0,1,1,1,0,0,6,2,0,0,0,0,1,1,0,0};		// Two multiplies
		rows[13] = '{0,1,1,1,0,0,7,2,0,0,0,0,1,1,1,6};
		rows[18] = '{0,0,0,0,0,0,0,0,0,0,0,0,1,1,1,7};
		for (int i = 19; i < 24; i++)				// Fill, then drop rob 12
			rows[i] = '{0,1,1,1,0,0,5'(i-11),1,0,0,0,0,0,1,0,0};
		for (int i = 24; i < 28; i++)
			rows[i] = '{0,0,0,0,0,0,0,0,0,0,0,0,1,1,1,5'(i-16)};
		rows[29] = '{0,1,1,1,0,0,13,1,0,0,0,0,0,1,0,0};
		rows[30] = '{1,0,0,0,0,0,0,0,0,0,0,0,0,1,0,0};		// Mid-run reset
		rows[33] = '{0,1,1,1,0,0,14,1,0,0,0,0,1,1,0,0};
		rows[34] = '{0,0,0,0,0,0,0,0,0,0,0,0,1,1,1,14};
		rows[35] = '{0,1,0,0,9,10,15,1,0,0,0,0,1,1,0,0};	// A on bus 1, B on bus 2
		rows[36] = '{0,0,0,0,0,0,0,0,1,9,1,10,1,1,0,0};
		rows[37] = '{0,0,0,0,0,0,0,0,0,0,0,0,1,1,1,15};
		apply_row(rows[0]);
		dispatch_valid = 1'b0;
		reset = 1'b1;
		repeat (4) @(posedge clock);
		for (int i = 0; i < ROWS; i++)
		begin
			@(posedge clock);
			#1 apply_row(rows[i]);
			exp_check = 1'b1;
		end
		@(posedge clock);
		#1 apply_row(row_t'{0,1,1,1,0,0,20,2,0,0,0,0,1,1,0,0});	// Untabled multiply
		exp_check = 1'b0;
		@(posedge clock);
		#1 apply_row(rows[14]);
		cycles = 0;
		while (!mult_done && cycles < 20)
		begin
			@(negedge clock);
			cycles++;
		end
		if (!mult_done)
		begin
			timeouts++;
			$display("Timed out waiting for mult_done after a multiply");
		end
		repeat (3) @(posedge clock);
		$display("Errors: %0d, timeouts: %0d", errors, timeouts);
		if (errors == 0 && timeouts == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

endmodule

`default_nettype wire
